// File: mem_subsys.f
rtl/lsu_pkg.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/mem_subsys.sv
testbench/mem_subsys_tb.sv

// File: Makefile
# Verilator simulation of the memory-access subsystem

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

  import lsu_pkg::*;

  typedef struct {
    load_t     ld;
    save_t     sv;
    reg_t      addr;
    reg_t      data;
    wb_sel_t   sel;
    logic      rd_ena;
    rd_addr_t  rd;
    logic      csr_ena;
    csr_addr_t csr;
  } entry_t;

  typedef struct {
    reg_t      pc;
    inst_t     inst;
    excp_t     excp;
    logic      rd_ena;
    rd_addr_t  rd;
    reg_t      rd_data;
    logic      csr_ena;
    csr_addr_t csr;
    int        acc_cyc;
    bit        stream;
  } commit_t;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_allowin;
  reg_t      pc;
  inst_t     inst;
  reg_t      alu_result;
  reg_t      reg_src;
  load_t     load_info;
  save_t     save_info;
  wb_sel_t   wb_sel;
  logic      csr_wr_ena;
  csr_addr_t csr_wr_addr;
  logic      rd_w_ena;
  rd_addr_t  rd_w_addr;
  logic      commit_ready;
  logic      commit_valid;
  reg_t      commit_pc;
  inst_t     commit_inst;
  excp_t     commit_excp;
  logic      commit_rd_ena;
  rd_addr_t  commit_rd_addr;
  reg_t      commit_rd_data;
  logic      commit_csr_ena;
  csr_addr_t commit_csr_addr;

  entry_t     tbl[$];
  commit_t    exp_q[$];
  string      ph_name[$];
  int         ph_first[$];
  int         ph_last[$];
  bit         ph_random[$];
  bit         ph_stream[$];
  logic [7:0] model_mem [dram_words*8];
  int         cyc;
  int         errors;
  int         checks;
  int         tests;
  int         failed;
  bit         rnd_ready;
  bit         built;
  bit         held;
  reg_t       held_pc;
  reg_t       held_data;

  mem_subsys DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // retire side is ready at random or always
  always @(posedge clk) begin
    #2;
    commit_ready = rnd_ready ? ($urandom % 2 == 1) : 1'b1;
  end

  function automatic int access_bytes(load_t ld, save_t sv);
    if (ld[load_ld] || sv[save_sd]) return 8;
    if (ld[load_lw] || ld[load_lwu] || sv[save_sw]) return 4;
    if (ld[load_lh] || ld[load_lhu] || sv[save_sh]) return 2;
    return 1;
  endfunction

  function automatic reg_t pc_of(int i);
    return 64'h8000_0000 + reg_t'(i) * 4;
  endfunction

  function automatic inst_t inst_of(int i);
    return 32'h0000_0013 | (inst_t'(i) << 7);
  endfunction

  task automatic load_entry(int k, reg_t addr);
    tbl.push_back('{load_t'(1 << k), '0, addr, '0, wb_sel_mem, 1'b1,
                    rd_addr_t'(tbl.size() % 31 + 1), 1'b0, '0});
  endtask

  task automatic store_entry(int k, reg_t addr, reg_t data);
    tbl.push_back('{'0, save_t'(1 << k), addr, data, wb_sel_alu, 1'b0, '0, 1'b0, '0});
  endtask

  task automatic alu_entry(reg_t value, wb_sel_t sel, rd_addr_t rd, logic csr_ena,
                           csr_addr_t csr);
    tbl.push_back('{'0, '0, value, '0, sel, rd != '0, rd, csr_ena, csr});
  endtask

  task automatic add_csr_write();
    entry_t e;
    e = tbl.pop_back();
    e.csr_ena = 1'b1;
    e.csr     = 12'h340;
    tbl.push_back(e);
  endtask

  task automatic open_test(string name, bit rnd, bit stream);
    ph_name.push_back(name);
    ph_first.push_back(tbl.size());
    ph_random.push_back(rnd);
    ph_stream.push_back(stream);
  endtask

  task automatic build_table();
    int k;
    int o;
    open_test("stores of every width, loads of every type", 1'b0, 1'b0);
    for (int w = 5; w <= 7; w++) store_entry(save_sd, reg_t'(w * 8),
                                             64'hf0e1_d2c3_b4a5_9687 ^ {8{8'(w)}});
    // each partial store is read back as a whole word
    for (o = 0; o < 8; o++) begin
      store_entry(save_sb, reg_t'(40 + o), 64'hdead_beef_0000_0080 + reg_t'(o));
      load_entry(load_ld, 64'd40);
    end
    for (o = 0; o < 8; o += 2) begin
      store_entry(save_sh, reg_t'(48 + o), 64'h1234_5678_9abc_8001 + reg_t'(o));
      load_entry(load_ld, 64'd48);
    end
    for (o = 0; o < 8; o += 4) begin
      store_entry(save_sw, reg_t'(56 + o), 64'h0bad_f00d_8765_4321 + reg_t'(o));
      load_entry(load_ld, 64'd56);
    end
    store_entry(save_sd, 64'd64, 64'h8877_6655_4433_2211);
    load_entry(load_ld, 64'd64);
    for (k = 0; k < load_w; k++)
      for (o = 0; o < 8; o += access_bytes(load_t'(1 << k), '0))
        load_entry(k, reg_t'(48 + o));
    ph_last.push_back(tbl.size());

    open_test("misaligned loads and stores", 1'b0, 1'b0);
    store_entry(save_sd, 64'h50, 64'h0123_4567_89ab_cdef);
    store_entry(save_sh, 64'h51, '1);
    // a fault drops the csr write too
    add_csr_write();
    store_entry(save_sw, 64'h52, '1);
    store_entry(save_sd, 64'h54, '1);
    load_entry(load_lh, 64'h53);
    add_csr_write();
    load_entry(load_lhu, 64'h55);
    load_entry(load_lw, 64'h56);
    load_entry(load_lwu, 64'h51);
    load_entry(load_ld, 64'h54);
    load_entry(load_ld, 64'h50);
    ph_last.push_back(tbl.size());

    open_test("non-memory instructions", 1'b0, 1'b0);
    alu_entry(64'h0, wb_sel_alu, 5'd1, 1'b0, 12'h000);
    alu_entry(64'hffff_ffff_ffff_fffe, wb_sel_alu, 5'd31, 1'b1, 12'h300);
    alu_entry(64'h7fff_0000_1234_abcd, wb_sel_pc4, 5'd1, 1'b1, 12'h341);
    alu_entry(64'h5555_aaaa_5555_aaaa, wb_sel_pc4, 5'd17, 1'b0, 12'hfff);
    alu_entry(64'h0000_0000_cafe_0000, wb_sel_alu, 5'd0, 1'b1, 12'h7c0);
    ph_last.push_back(tbl.size());

    open_test("random back-pressure", 1'b1, 1'b0);
    for (int w = 16; w < 20; w++) store_entry(save_sd, reg_t'(w * 8), {$urandom, $urandom});
    for (int i = 0; i < 24; i++) begin
      k = int'($urandom % 3);
      if (k == 0) begin
        alu_entry({$urandom, $urandom}, ($urandom % 2 == 1) ? wb_sel_pc4 : wb_sel_alu,
                  rd_addr_t'($urandom % 32), 1'b1, csr_addr_t'($urandom % 4096));
      end else begin
        k = (k == 1) ? int'($urandom % save_w) : int'($urandom % load_w);
        o = int'($urandom % 8);
        if (i % 2 == 0) begin
          o = o & ~(access_bytes('0, save_t'(1 << (k % save_w))) - 1);
          store_entry(k % save_w, reg_t'(128 + 8 * ($urandom % 4) + o),
                      {$urandom, $urandom});
        end else begin
          o = o & ~(access_bytes(load_t'(1 << k), '0) - 1);
          load_entry(k, reg_t'(128 + 8 * ($urandom % 4) + o));
        end
      end
    end
    ph_last.push_back(tbl.size());

    open_test("back-to-back streaming", 1'b0, 1'b1);
    store_entry(save_sd, 64'hc0, 64'h8000_0000_ffff_0001);
    load_entry(load_ld, 64'hc0);
    store_entry(save_sb, 64'hc3, 64'h0000_0000_0000_00a5);
    load_entry(load_lbu, 64'hc3);
    alu_entry(64'h1, wb_sel_pc4, 5'd9, 1'b0, 12'h000);
    store_entry(save_sw, 64'hc4, 64'h0000_0000_8765_4321);
    load_entry(load_lw, 64'hc4);
    load_entry(load_lh, 64'hc6);
    alu_entry(64'h42, wb_sel_alu, 5'd10, 1'b1, 12'h305);
    ph_last.push_back(tbl.size());
  endtask

  task automatic drive_entry(int i);
    in_valid    = 1'b1;
    pc          = pc_of(i);
    inst        = inst_of(i);
    alu_result  = tbl[i].addr;
    reg_src     = tbl[i].data;
    load_info   = tbl[i].ld;
    save_info   = tbl[i].sv;
    wb_sel      = tbl[i].sel;
    csr_wr_ena  = tbl[i].csr_ena;
    csr_wr_addr = tbl[i].csr;
    rd_w_ena    = tbl[i].rd_ena;
    rd_w_addr   = tbl[i].rd;
  endtask

  // model update and expected commit at the accept edge
  task automatic expect_commit(int i, bit stream);
    entry_t  e;
    commit_t c;
    int      n;
    int      base;
    bit      bad;
    e = tbl[i];
    n = access_bytes(e.ld, e.sv);
    base = int'(e.addr[10:0]);
    bad = (e.ld != '0 || e.sv != '0) && (int'(e.addr[2:0]) % n != 0);
    if (e.sv != '0 && !bad)
      for (int b = 0; b < n; b++) model_mem[base + b] = e.data[8*b +: 8];
    c.rd_data = (e.sel == wb_sel_pc4) ? pc_of(i) + 64'd4 : e.addr;
    if (e.ld != '0) begin
      c.rd_data = '0;
      for (int b = 0; b < n; b++) c.rd_data[8*b +: 8] = model_mem[base + b];
      if (e.ld[load_lb] || e.ld[load_lh] || e.ld[load_lw])
        for (int b = n; b < 8; b++) c.rd_data[8*b +: 8] = {8{c.rd_data[8*n-1]}};
    end
    c.excp = '0;
    if (bad) c.excp[e.ld != '0 ? excp_load_misalign : excp_store_misalign] = 1'b1;
    c.pc      = pc_of(i);
    c.inst    = inst_of(i);
    c.rd_ena  = e.rd_ena && !bad;
    c.rd      = e.rd;
    c.csr_ena = e.csr_ena && !bad;
    c.csr     = e.csr;
    c.acc_cyc = cyc;
    c.stream  = stream;
    exp_q.push_back(c);
  endtask

  task automatic check_field(string name, reg_t got, reg_t want);
    if (got !== want) begin
      $display("error: %s got %h expected %h (pc %h)", name, got, want, commit_pc);
      errors++;
    end
  endtask

  task automatic retire_check();
    commit_t c;
    if (exp_q.size() == 0) begin
      $display("retirement at pc %h with no instruction outstanding", commit_pc);
      errors++;
      return;
    end
    c = exp_q.pop_front();
    checks++;
    check_field("commit_pc", commit_pc, c.pc);
    check_field("commit_inst", reg_t'(commit_inst), reg_t'(c.inst));
    check_field("commit_excp", reg_t'(commit_excp), reg_t'(c.excp));
    check_field("commit_rd_ena", reg_t'(commit_rd_ena), reg_t'(c.rd_ena));
    check_field("commit_rd_addr", reg_t'(commit_rd_addr), reg_t'(c.rd));
    check_field("commit_csr_ena", reg_t'(commit_csr_ena), reg_t'(c.csr_ena));
    check_field("commit_csr_addr", reg_t'(commit_csr_addr), reg_t'(c.csr));
    if (c.excp == '0) check_field("commit_rd_data", commit_rd_data, c.rd_data);
    if (c.stream && cyc - c.acc_cyc != 2) begin
      $display("pc %h retired %0d cycles after accept instead of 2", c.pc, cyc - c.acc_cyc);
      errors++;
    end
  endtask

  // retirements and hold under back-pressure sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (held && (commit_valid !== 1'b1 || commit_pc !== held_pc
                   || commit_rd_data !== held_data)) begin
        $display("commit outputs changed while commit_ready was low (pc %h)", held_pc);
        errors++;
      end
      held      = commit_valid && !commit_ready;
      held_pc   = commit_pc;
      held_data = commit_rd_data;
      if (commit_valid && commit_ready) retire_check();
    end
  end

  task automatic report_test(string name, int base_err);
    tests++;
    if (errors != base_err) failed++;
    $display("%s: %s, %0d errors", name, errors == base_err ? "passed" : "failed",
             errors - base_err);
  endtask

  initial begin
    int  base_err;
    bit  accepted;
    void'($urandom(32'hd9a4dc62));
    rst = 1'b1;
    in_valid = 1'b0;
    pc = '0;
    inst = '0;
    alu_result = '0;
    reg_src = '0;
    load_info = '0;
    save_info = '0;
    wb_sel = wb_sel_alu;
    csr_wr_ena = 1'b0;
    csr_wr_addr = '0;
    rd_w_ena = 1'b0;
    rd_w_addr = '0;
    commit_ready = 1'b0;
    rnd_ready = 1'b0;
    build_table();
    built = 1'b1;

    base_err = errors;
    repeat (16) begin
      @(posedge clk);
      #2;
      if (commit_valid !== 1'b0) begin
        $display("error: commit_valid got %h expected 0 during reset", commit_valid);
        errors++;
      end
    end
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (commit_valid !== 1'b0 || in_allowin !== 1'b1) begin
        $display("error: commit_valid %h in_allowin %h after reset, expected 0 and 1",
                 commit_valid, in_allowin);
        errors++;
      end
    end
    report_test("reset", base_err);

    for (int p = 0; p < ph_name.size(); p++) begin
      base_err = errors;
      rnd_ready = ph_random[p];
      @(posedge clk);
      #2;
      for (int i = ph_first[p]; i < ph_last[p]; i++) begin
        drive_entry(i);
        accepted = 1'b0;
        while (!accepted) begin
          @(negedge clk);
          if (in_allowin) begin
            accepted = 1'b1;
            expect_commit(i, ph_stream[p]);
          end else if (ph_stream[p]) begin
            $display("in_allowin dropped during streaming at pc %h", pc);
            errors++;
          end
          @(posedge clk);
          #2;
        end
      end
      in_valid = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      report_test(ph_name[p], base_err);
    end

    $display("%0d tests, %0d failed, %0d retirements checked, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog allows 20 cycles per table entry plus reset
  initial begin
    wait (built);
    repeat (tbl.size() * 20 + 16) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", tbl.size() * 20 + 16);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: rtl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
  input  logic                clk,
  input  logic                rst,

  // execute side
  input  logic                in_valid,
  output logic                in_allowin,
  input  lsu_pkg::reg_t       pc,
  input  lsu_pkg::inst_t      inst,
  input  lsu_pkg::reg_t       alu_result,
  input  lsu_pkg::reg_t       reg_src,
  input  lsu_pkg::load_t      load_info,
  input  lsu_pkg::save_t      save_info,
  input  lsu_pkg::wb_sel_t    wb_sel,
  input  logic                csr_wr_ena,
  input  lsu_pkg::csr_addr_t  csr_wr_addr,
  input  logic                rd_w_ena,
  input  lsu_pkg::rd_addr_t   rd_w_addr,

  // retire side
  input  logic                commit_ready,
  output logic                commit_valid,
  output lsu_pkg::reg_t       commit_pc,
  output lsu_pkg::inst_t      commit_inst,
  output lsu_pkg::excp_t      commit_excp,
  output logic                commit_rd_ena,
  output lsu_pkg::rd_addr_t   commit_rd_addr,
  output lsu_pkg::reg_t       commit_rd_data,
  output logic                commit_csr_ena,
  output lsu_pkg::csr_addr_t  commit_csr_addr
);

  import lsu_pkg::*;

  logic      mem_wb_valid;
  logic      wb_allowin;
  byte_en_t  byte_enable;
  reg_t      ram_wr_data;
  reg_t      ram_rd_data;
  reg_t      mw_pc;
  inst_t     mw_inst;
  reg_t      mw_alu_result;
  reg_t      mw_mem_data;
  wb_sel_t   mw_wb_sel;
  excp_t     mw_excp;
  logic      mw_csr_wr_ena;
  csr_addr_t mw_csr_wr_addr;
  logic      mw_rd_w_ena;
  rd_addr_t  mw_rd_w_addr;

  mem_stage u_mem_stage (
    .clk             (clk),
    .rst             (rst),
    .ex_mem_valid    (in_valid),
    .mem_allowin     (in_allowin),
    .wb_allowin      (wb_allowin),
    .mem_wb_valid    (mem_wb_valid),
    .pc_in           (pc),
    .inst_in         (inst),
    .alu_result_in   (alu_result),
    .reg_src         (reg_src),
    .load_info       (load_info),
    .save_info       (save_info),
    .wb_sel_in       (wb_sel),
    .csr_wr_ena_in   (csr_wr_ena),
    .csr_wr_addr_in  (csr_wr_addr),
    .rd_w_ena_in     (rd_w_ena),
    .rd_w_addr_in    (rd_w_addr),
    .ram_rd_data     (ram_rd_data),
    .byte_enable     (byte_enable),
    .ram_wr_data     (ram_wr_data),
    .pc_out          (mw_pc),
    .inst_out        (mw_inst),
    .alu_result_out  (mw_alu_result),
    .mem_data        (mw_mem_data),
    .wb_sel_out      (mw_wb_sel),
    .mem_excp        (mw_excp),
    .csr_wr_ena_out  (mw_csr_wr_ena),
    .csr_wr_addr_out (mw_csr_wr_addr),
    .rd_w_ena_out    (mw_rd_w_ena),
    .rd_w_addr_out   (mw_rd_w_addr)
  );

  // word index straight from the execute-side address
  data_ram u_data_ram (
    .clk         (clk),
    .addr        (alu_result[dram_addr_lsb +: dram_addr_w]),
    .byte_enable (byte_enable),
    .wr_data     (ram_wr_data),
    .rd_data     (ram_rd_data)
  );

  wb_stage u_wb_stage (
    .clk             (clk),
    .rst             (rst),
    .mem_wb_valid    (mem_wb_valid),
    .wb_allowin      (wb_allowin),
    .commit_ready    (commit_ready),
    .commit_valid    (commit_valid),
    .pc_in           (mw_pc),
    .inst_in         (mw_inst),
    .alu_result      (mw_alu_result),
    .mem_data        (mw_mem_data),
    .wb_sel          (mw_wb_sel),
    .excp_in         (mw_excp),
    .csr_wr_ena_in   (mw_csr_wr_ena),
    .csr_wr_addr_in  (mw_csr_wr_addr),
    .rd_w_ena_in     (mw_rd_w_ena),
    .rd_w_addr_in    (mw_rd_w_addr),
    .commit_pc       (commit_pc),
    .commit_inst     (commit_inst),
    .commit_excp     (commit_excp),
    .commit_rd_ena   (commit_rd_ena),
    .commit_rd_addr  (commit_rd_addr),
    .commit_rd_data  (commit_rd_data),
    .commit_csr_ena  (commit_csr_ena),
    .commit_csr_addr (commit_csr_addr)
  );

endmodule

// File: rtl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
  input  logic                clk,
  input  logic                rst,

  input  logic                mem_wb_valid,
  output logic                wb_allowin,
  input  logic                commit_ready,
  output logic                commit_valid,

  input  lsu_pkg::reg_t       pc_in,
  input  lsu_pkg::inst_t      inst_in,
  input  lsu_pkg::reg_t       alu_result,
  input  lsu_pkg::reg_t       mem_data,
  input  lsu_pkg::wb_sel_t    wb_sel,
  input  lsu_pkg::excp_t      excp_in,
  input  logic                csr_wr_ena_in,
  input  lsu_pkg::csr_addr_t  csr_wr_addr_in,
  input  logic                rd_w_ena_in,
  input  lsu_pkg::rd_addr_t   rd_w_addr_in,

  output lsu_pkg::reg_t       commit_pc,
  output lsu_pkg::inst_t      commit_inst,
  output lsu_pkg::excp_t      commit_excp,
  output logic                commit_rd_ena,
  output lsu_pkg::rd_addr_t   commit_rd_addr,
  output lsu_pkg::reg_t       commit_rd_data,
  output logic                commit_csr_ena,
  output lsu_pkg::csr_addr_t  commit_csr_addr
);

  import lsu_pkg::*;

  logic wb_valid;
  logic transfer;
  logic rd_ena_q;
  logic csr_ena_q;
  reg_t wb_value;

  assign wb_allowin   = !wb_valid || commit_ready;
  assign commit_valid = wb_valid;
  assign transfer     = mem_wb_valid && wb_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_wb_valid;
    end
  end

  // destination value
  always_comb begin
    case (wb_sel)
      wb_sel_mem: wb_value = mem_data;
      wb_sel_pc4: wb_value = pc_in + reg_t'(4);
      default:    wb_value = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      commit_pc       <= pc_in;
      commit_inst     <= inst_in;
      commit_excp     <= excp_in;
      commit_rd_data  <= wb_value;
      commit_rd_addr  <= rd_w_addr_in;
      commit_csr_addr <= csr_wr_addr_in;
      rd_ena_q        <= rd_w_ena_in;
      csr_ena_q       <= csr_wr_ena_in;
    end
  end

  // an excepting instruction writes nothing
  assign commit_rd_ena  = rd_ena_q && (commit_excp == '0);
  assign commit_csr_ena = csr_ena_q && (commit_excp == '0);

  a_commit_hold: assert property (@(posedge clk) disable iff (rst)
    commit_valid && !commit_ready |=>
      commit_valid && $stable(commit_pc) && $stable(commit_inst)
      && $stable(commit_excp) && $stable(commit_rd_data)
      && $stable(commit_rd_ena) && $stable(commit_rd_addr)
      && $stable(commit_csr_ena) && $stable(commit_csr_addr));

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic                clk,
  input  lsu_pkg::dram_addr_t addr,
  input  lsu_pkg::byte_en_t   byte_enable,
  input  lsu_pkg::reg_t       wr_data,
  output lsu_pkg::reg_t       rd_data
);

  import lsu_pkg::*;

  reg_t mem [dram_words];

  // combinational read
  assign rd_data = mem[addr];

  // byte-lane write
  always_ff @(posedge clk) begin
    for (int i = 0; i < byte_en_w; i++) begin
      if (byte_enable[i]) begin
        mem[addr][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                clk,
  input  logic                rst,

  input  logic                ex_mem_valid,
  output logic                mem_allowin,
  input  logic                wb_allowin,
  output logic                mem_wb_valid,

  input  lsu_pkg::reg_t       pc_in,
  input  lsu_pkg::inst_t      inst_in,
  input  lsu_pkg::reg_t       alu_result_in,
  input  lsu_pkg::reg_t       reg_src,
  input  lsu_pkg::load_t      load_info,
  input  lsu_pkg::save_t      save_info,
  input  lsu_pkg::wb_sel_t    wb_sel_in,
  input  logic                csr_wr_ena_in,
  input  lsu_pkg::csr_addr_t  csr_wr_addr_in,
  input  logic                rd_w_ena_in,
  input  lsu_pkg::rd_addr_t   rd_w_addr_in,

  // data memory side
  input  lsu_pkg::reg_t       ram_rd_data,
  output lsu_pkg::byte_en_t   byte_enable,
  output lsu_pkg::reg_t       ram_wr_data,

  output lsu_pkg::reg_t       pc_out,
  output lsu_pkg::inst_t      inst_out,
  output lsu_pkg::reg_t       alu_result_out,
  output lsu_pkg::reg_t       mem_data,
  output lsu_pkg::wb_sel_t    wb_sel_out,
  output lsu_pkg::excp_t      mem_excp,
  output logic                csr_wr_ena_out,
  output lsu_pkg::csr_addr_t  csr_wr_addr_out,
  output logic                rd_w_ena_out,
  output lsu_pkg::rd_addr_t   rd_w_addr_out
);

  import lsu_pkg::*;

  logic     mem_valid;
  logic     accept;
  logic     is_load;
  logic     is_store;
  logic     acc_half;
  logic     acc_word;
  logic     acc_dword;
  logic     misalign;
  logic [2:0] offset;
  byte_en_t size_mask;
  byte_en_t lane_mask;
  reg_t     mem_part;
  reg_t     load_ext;
  excp_t    excp_d;

  // valid/allowin, the stage never stalls on its own
  assign mem_allowin  = !mem_valid || wb_allowin;
  assign mem_wb_valid = mem_valid;
  assign accept       = ex_mem_valid && mem_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_mem_valid;
    end
  end

  assign offset   = alu_result_in[2:0];
  assign is_load  = |load_info;
  assign is_store = |save_info;

  // access size
  assign acc_half  = load_info[load_lh] | load_info[load_lhu] | save_info[save_sh];
  assign acc_word  = load_info[load_lw] | load_info[load_lwu] | save_info[save_sw];
  assign acc_dword = load_info[load_ld] | save_info[save_sd];

  assign misalign = (acc_half & offset[0])
                  | (acc_word & (|offset[1:0]))
                  | (acc_dword & (|offset));

  always_comb begin
    excp_d = '0;
    excp_d[excp_load_misalign]  = is_load & misalign;
    excp_d[excp_store_misalign] = is_store & misalign;
  end

  // store lanes
  always_comb begin
    case (1'b1)
      save_info[save_sb]: size_mask = 8'h01;
      save_info[save_sh]: size_mask = 8'h03;
      save_info[save_sw]: size_mask = 8'h0f;
      save_info[save_sd]: size_mask = 8'hff;
      default:            size_mask = 8'h00;
    endcase
  end

  assign lane_mask   = size_mask << offset;
  assign ram_wr_data = reg_src << {offset, 3'b000};

  // only an accepted, aligned store writes
  assign byte_enable = (accept && !misalign) ? lane_mask : '0;

  // load extension
  assign mem_part = ram_rd_data >> {offset, 3'b000};

  always_comb begin
    case (1'b1)
      load_info[load_lb]:  load_ext = {{(xlen-8){mem_part[7]}}, mem_part[7:0]};
      load_info[load_lh]:  load_ext = {{(xlen-16){mem_part[15]}}, mem_part[15:0]};
      load_info[load_lw]:  load_ext = {{(xlen-32){mem_part[31]}}, mem_part[31:0]};
      load_info[load_ld]:  load_ext = mem_part;
      load_info[load_lbu]: load_ext = {{(xlen-8){1'b0}}, mem_part[7:0]};
      load_info[load_lhu]: load_ext = {{(xlen-16){1'b0}}, mem_part[15:0]};
      load_info[load_lwu]: load_ext = {{(xlen-32){1'b0}}, mem_part[31:0]};
      default:             load_ext = '0;
    endcase
  end

  // payload, captured at accept
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_out          <= pc_in;
      inst_out        <= inst_in;
      alu_result_out  <= alu_result_in;
      mem_data        <= load_ext;
      wb_sel_out      <= wb_sel_in;
      mem_excp        <= excp_d;
      csr_wr_ena_out  <= csr_wr_ena_in;
      csr_wr_addr_out <= csr_wr_addr_in;
      rd_w_ena_out    <= rd_w_ena_in;
      rd_w_addr_out   <= rd_w_addr_in;
    end
  end

  a_load_onehot: assert property (@(posedge clk) disable iff (rst)
    ex_mem_valid |-> $onehot0(load_info));

  a_save_onehot: assert property (@(posedge clk) disable iff (rst)
    ex_mem_valid |-> $onehot0(save_info));

  a_load_xor_save: assert property (@(posedge clk) disable iff (rst)
    ex_mem_valid |-> !(is_load && is_store));

  a_no_write_idle: assert property (@(posedge clk) disable iff (rst)
    !ex_mem_valid |-> (byte_enable == '0));

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  // datapath widths
  localparam int xlen       = 64;
  localparam int inst_w     = 32;
  localparam int rd_addr_w  = 5;
  localparam int csr_addr_w = 12;
  localparam int byte_en_w  = xlen / 8;

  typedef logic [xlen-1:0]       reg_t;
  typedef logic [inst_w-1:0]     inst_t;
  typedef logic [rd_addr_w-1:0]  rd_addr_t;
  typedef logic [csr_addr_w-1:0] csr_addr_t;
  typedef logic [byte_en_w-1:0]  byte_en_t;

  // one-hot load codes, all zeros when not a load
  localparam int load_w   = 7;
  localparam int load_lb  = 0;
  localparam int load_lh  = 1;
  localparam int load_lw  = 2;
  localparam int load_ld  = 3;
  localparam int load_lbu = 4;
  localparam int load_lhu = 5;
  localparam int load_lwu = 6;

  typedef logic [load_w-1:0] load_t;

  // one-hot store codes
  localparam int save_w  = 4;
  localparam int save_sb = 0;
  localparam int save_sh = 1;
  localparam int save_sw = 2;
  localparam int save_sd = 3;

  typedef logic [save_w-1:0] save_t;

  // write-back source
  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t wb_sel_alu = 2'd0;
  localparam wb_sel_t wb_sel_mem = 2'd1;
  localparam wb_sel_t wb_sel_pc4 = 2'd2;

  // exception bits
  localparam int excp_w              = 2;
  localparam int excp_load_misalign  = 0;
  localparam int excp_store_misalign = 1;

  typedef logic [excp_w-1:0] excp_t;

  // data memory geometry, one 64-bit word per index
  localparam int dram_words    = 256;
  localparam int dram_addr_w   = $clog2(dram_words);
  localparam int dram_addr_lsb = $clog2(byte_en_w);

  typedef logic [dram_addr_w-1:0] dram_addr_t;

endpackage
